//--- bbc_pkg.sv
package bbc_pkg;

	// cpu address seen flat or split into 16 KB pages
	typedef union packed {
		logic [15:0] flat;
		struct packed {
			logic [1:0]  page;   // 3 mos, 2 sideways, 0/1 ram
			logic [13:0] offset;
		} paged;
	} cpu_addr_u;

	// memory bus as it leaves the 6502 core
	typedef struct packed {
		cpu_addr_u   addr;
		logic        we;
		logic [7:0]  dout;
	} cpu_bus_t;

	// downloader port strobed on mem_sync
	typedef struct packed {
		logic        active;
		logic        we;
		logic [24:0] addr;
		logic [7:0]  data;
	} loader_bus_t;

	// request into main memory
	typedef struct packed {
		logic [24:0] addr;
		logic        we;
		logic [7:0]  data;
	} mem_req_t;

	typedef enum logic [2:0] {
		SRC_RAM   = 3'd0,
		SRC_MOS   = 3'd1,
		SRC_BASIC = 3'd2,
		SRC_MMFS  = 3'd3,
		SRC_NONE  = 3'd4
	} src_sel_e;

	// menu status bits used here
	typedef struct packed {
		logic osd_reset;
		logic rom_map_low;   // 1 = low rom mapping
		logic autoboot_en;
		logic menu_reset;
	} status_t;

	// rom select codes
	localparam logic [3:0] ROMSEL_BASIC_HI = 4'he;
	localparam logic [3:0] ROMSEL_BASIC_LO = 4'h0;
	localparam logic [3:0] ROMSEL_MMFS_HI  = 4'hc;
	localparam logic [3:0] ROMSEL_MMFS_LO  = 4'h2;
	localparam logic [3:0] ROMSEL_RAM_A    = 4'ha;
	localparam logic [1:0] SW_RAM_GROUP    = 2'b01;   // banks 4..7

	// address regions
	localparam logic [1:0] PAGE_SIDEWAYS = 2'd2;
	localparam logic [1:0] PAGE_MOS      = 2'd3;
	localparam logic [6:0] SIDEWAYS_BASE = 7'b0000001;   // sideways area above main ram

endpackage

//--- mem_map_decode.sv
`timescale 1ns/1ps
module mem_map_decode (
	input  logic                  clk_32m,
	input  logic                  reset,
	input  logic                  mem_sync_i,
	input  bbc_pkg::cpu_bus_t     cpu_i,
	input  logic [3:0]            romsel_i,
	input  logic                  rom_map_low_i,
	input  bbc_pkg::loader_bus_t  loader_i,
	output bbc_pkg::mem_req_t     ram_req_o,
	output logic [13:0]           rom_offset_o,
	output bbc_pkg::src_sel_e     rom_src_o,
	input  logic [7:0]            ram_di_i,
	input  logic [7:0]            mos_di_i,
	input  logic [7:0]            basic_di_i,
	input  logic [7:0]            mmfs_di_i,
	output logic [7:0]            cpu_di_o
);
	import bbc_pkg::*;

	logic        cpu_ram;
	logic        mos_rom;
	logic        sw_page;
	logic        sw_ram;
	logic        basic_map;
	logic        mmfs_map;
	logic [24:0] cpu_addr;
	logic        cpu_we;
	src_sel_e    src_d;
	src_sel_e    src_q;

	// page classification
	assign cpu_ram = ~cpu_i.addr.paged.page[1];
	assign mos_rom = (cpu_i.addr.paged.page == PAGE_MOS);
	assign sw_page = (cpu_i.addr.paged.page == PAGE_SIDEWAYS);
	assign sw_ram  = sw_page && (romsel_i[3:2] == SW_RAM_GROUP);   // 64k sideways ram

	// basic and mmfs move with the mapping option
	assign basic_map = rom_map_low_i ? (romsel_i == ROMSEL_BASIC_LO) :
		(romsel_i == ROMSEL_BASIC_HI);
	assign mmfs_map = rom_map_low_i ? (romsel_i == ROMSEL_MMFS_LO) :
		(romsel_i == ROMSEL_MMFS_HI);

	always_comb begin
		if (cpu_ram)
			src_d = SRC_RAM;
		else if (mos_rom)
			src_d = SRC_MOS;
		else if (basic_map)
			src_d = SRC_BASIC;
		else if (mmfs_map)
			src_d = SRC_MMFS;
		else if ((romsel_i == ROMSEL_RAM_A) || sw_ram)
			src_d = SRC_RAM;   // bank a is read only
		else
			src_d = SRC_NONE;
	end

	assign cpu_addr = cpu_ram ? {9'd0, cpu_i.addr.flat} :
		{SIDEWAYS_BASE, romsel_i, cpu_i.addr.paged.offset};
	assign cpu_we = cpu_i.we && (cpu_ram || sw_ram);

	// loader takes over the ram port while it runs
	always_comb begin
		if (loader_i.active) begin
			ram_req_o.addr = loader_i.addr;
			ram_req_o.data = loader_i.data;
			ram_req_o.we   = loader_i.we && mem_sync_i;
		end else begin
			ram_req_o.addr = cpu_addr;
			ram_req_o.data = cpu_i.dout;
			ram_req_o.we   = cpu_we && mem_sync_i;   // one write per sync slot
		end
	end

	// select follows the data one cycle later
	always_ff @(posedge clk_32m) begin
		if (reset)
			src_q <= SRC_NONE;
		else
			src_q <= src_d;
	end

	assign rom_offset_o = cpu_i.addr.paged.offset;
	assign rom_src_o    = src_q;

	always_comb begin
		case (src_q)
			SRC_RAM:   cpu_di_o = ram_di_i;
			SRC_MOS:   cpu_di_o = mos_di_i;
			SRC_BASIC: cpu_di_o = basic_di_i;
			SRC_MMFS:  cpu_di_o = mmfs_di_i;
			default:   cpu_di_o = 8'hff;   // empty bank
		endcase
	end

endmodule

//--- sys_reset_ctrl.sv
`timescale 1ns/1ps
module sys_reset_ctrl #(
	parameter int REMAP_CYCLES    = 4095,
	parameter int AUTOBOOT_CYCLES = 32000000
) (
	input  logic              clk_32m,
	input  logic              reset,
	input  logic              mem_sync_i,
	input  logic              pll_ready_i,
	input  bbc_pkg::status_t  status_i,
	input  logic              button_reset_i,
	input  logic              loader_active_i,
	output logic              core_reset_o,
	output logic              autoboot_shift_o
);

	localparam int REMAP_W = $clog2(REMAP_CYCLES + 1);
	localparam int BOOT_W  = $clog2(AUTOBOOT_CYCLES + 1);

	logic               rom_map_q;
	logic [REMAP_W-1:0] remap_cnt;
	logic               remap_win;
	logic               reset_req;
	logic               core_reset_q;
	logic [BOOT_W-1:0]  boot_cnt;

	// a change of rom mapping holds the core in reset for a while
	always_ff @(posedge clk_32m) begin
		rom_map_q <= status_i.rom_map_low;
		if (reset)
			remap_cnt <= '0;
		else if (rom_map_q != status_i.rom_map_low)
			remap_cnt <= REMAP_W'(REMAP_CYCLES);
		else if (remap_cnt != '0)
			remap_cnt <= remap_cnt - 1'b1;
	end

	assign remap_win = (remap_cnt != '0);

	assign reset_req = ~pll_ready_i
		| status_i.osd_reset
		| status_i.menu_reset
		| button_reset_i
		| loader_active_i   // rom upload in progress
		| remap_win;

	// only change on memory sync slots
	always_ff @(posedge clk_32m) begin
		if (reset)
			core_reset_q <= 1'b1;
		else if (mem_sync_i)
			core_reset_q <= reset_req;
	end

	assign core_reset_o = core_reset_q;

	// shift held for a while after release to autoboot
	always_ff @(posedge clk_32m) begin
		if (reset)
			boot_cnt <= '0;
		else if (core_reset_q)
			boot_cnt <= BOOT_W'(AUTOBOOT_CYCLES);
		else if (boot_cnt != '0)
			boot_cnt <= boot_cnt - 1'b1;
	end

	// no shift while the core is still held
	assign autoboot_shift_o = status_i.autoboot_en && !core_reset_q && (boot_cnt != '0);

endmodule

//--- rom_bank.sv
`timescale 1ns/1ps
module rom_bank #(
	parameter int ROM_AW = 4
) (
	input  logic        clk_32m,
	input  logic [13:0] offset_i,
	output logic [7:0]  mos_o,
	output logic [7:0]  basic_o,
	output logic [7:0]  mmfs_o
);

	localparam int DEPTH = 2 ** ROM_AW;

	// image holds mos, basic, mmfs back to back
	logic [7:0] rom_mem [0:3*DEPTH-1];

	logic [ROM_AW-1:0] rom_addr;
	logic [7:0]        mos_q;
	logic [7:0]        basic_q;
	logic [7:0]        mmfs_q;

	initial begin
		$readmemh("rom_image.hex", rom_mem);
	end

	assign rom_addr = offset_i[ROM_AW-1:0];   // upper bits fold onto small image

	// all three read in parallel, decode picks one
	always_ff @(posedge clk_32m) begin
		mos_q   <= rom_mem[{2'd0, rom_addr}];
		basic_q <= rom_mem[{2'd1, rom_addr}];
		mmfs_q  <= rom_mem[{2'd2, rom_addr}];
	end

	assign mos_o   = mos_q;
	assign basic_o = basic_q;
	assign mmfs_o  = mmfs_q;

endmodule

//--- main_mem.sv
`timescale 1ns/1ps
module main_mem #(
	parameter int RAM_AW = 19
) (
	input  logic               clk_32m,
	input  logic               mem_sync_i,
	input  bbc_pkg::mem_req_t  req_i,
	output logic [7:0]         dout_o
);

	localparam int DEPTH = 2 ** RAM_AW;

	logic [7:0]        ram [0:DEPTH-1];
	logic [RAM_AW-1:0] ram_addr;
	logic              ram_we;
	logic [7:0]        dout_q;

	// stands in for the sdram, so only the low address bits exist
	assign ram_addr = req_i.addr[RAM_AW-1:0];

	// sdram only takes a write in its sync slot
	assign ram_we = req_i.we && mem_sync_i;

	always_ff @(posedge clk_32m) begin
		if (ram_we)
			ram[ram_addr] <= req_i.data;
	end

	// read returns old data on a same cycle write
	always_ff @(posedge clk_32m) begin
		dout_q <= ram[ram_addr];
	end

	assign dout_o = dout_q;

endmodule

//--- bbc_mem_top.sv
`timescale 1ns/1ps
module bbc_mem_top #(
	parameter int ROM_AW          = 4,
	parameter int RAM_AW          = 19,
	parameter int REMAP_CYCLES    = 4095,
	parameter int AUTOBOOT_CYCLES = 32000000
) (
	input  logic                  clk_32m,
	input  logic                  reset,
	input  logic                  mem_sync_i,
	input  bbc_pkg::cpu_bus_t     cpu_i,
	input  logic [3:0]            romsel_i,
	input  bbc_pkg::status_t      status_i,
	input  bbc_pkg::loader_bus_t  loader_i,
	input  logic                  button_reset_i,
	input  logic                  pll_ready_i,
	output logic [7:0]            cpu_di_o,
	output logic                  core_reset_o,
	output logic                  autoboot_shift_o
);
	import bbc_pkg::*;

	mem_req_t    ram_req;
	logic [13:0] rom_offset;
	logic [7:0]  ram_do;
	logic [7:0]  mos_do;
	logic [7:0]  basic_do;
	logic [7:0]  mmfs_do;

	mem_map_decode u_decode (
		.clk_32m       (clk_32m),
		.reset         (reset),
		.mem_sync_i    (mem_sync_i),
		.cpu_i         (cpu_i),
		.romsel_i      (romsel_i),
		.rom_map_low_i (status_i.rom_map_low),
		.loader_i      (loader_i),
		.ram_req_o     (ram_req),
		.rom_offset_o  (rom_offset),
		.rom_src_o     (),   // mux select stays inside the decoder
		.ram_di_i      (ram_do),
		.mos_di_i      (mos_do),
		.basic_di_i    (basic_do),
		.mmfs_di_i     (mmfs_do),
		.cpu_di_o      (cpu_di_o)
	);

	sys_reset_ctrl #(
		.REMAP_CYCLES    (REMAP_CYCLES),
		.AUTOBOOT_CYCLES (AUTOBOOT_CYCLES)
	) u_reset (
		.clk_32m          (clk_32m),
		.reset            (reset),
		.mem_sync_i       (mem_sync_i),
		.pll_ready_i      (pll_ready_i),
		.status_i         (status_i),
		.button_reset_i   (button_reset_i),
		.loader_active_i  (loader_i.active),
		.core_reset_o     (core_reset_o),
		.autoboot_shift_o (autoboot_shift_o)
	);

	rom_bank #(
		.ROM_AW (ROM_AW)
	) u_roms (
		.clk_32m  (clk_32m),
		.offset_i (rom_offset),
		.mos_o    (mos_do),
		.basic_o  (basic_do),
		.mmfs_o   (mmfs_do)
	);

	main_mem #(
		.RAM_AW (RAM_AW)
	) u_ram (
		.clk_32m    (clk_32m),
		.mem_sync_i (mem_sync_i),
		.req_i      (ram_req),
		.dout_o     (ram_do)
	);

endmodule

//--- bbc_mem_props.sv
`timescale 1ns/1ps
module bbc_mem_props (
	input  logic clk_32m,
	input  logic rst_i,
	input  logic mem_sync_i,
	input  logic wr_i,
	input  logic core_reset_i,
	input  logic shift_i
);

	// ram only written in a sync slot
	a_write_sync : assert property (@(posedge clk_32m) wr_i |-> mem_sync_i)
		else $error("ram write outside mem_sync");

	// core reset moves only on sync edges
	a_reset_sync : assert property (@(posedge clk_32m) disable iff (rst_i)
		(core_reset_i != $past(core_reset_i)) |-> $past(mem_sync_i))
		else $error("core reset changed without mem_sync");

	a_shift_in_reset : assert property (@(posedge clk_32m) core_reset_i |-> !shift_i)
		else $error("autoboot shift high during core reset");

endmodule

bind sys_reset_ctrl bbc_mem_props u_reset_props (
	.clk_32m      (clk_32m),
	.rst_i        (reset),
	.mem_sync_i   (mem_sync_i),
	.wr_i         (1'b0),
	.core_reset_i (core_reset_q),
	.shift_i      (autoboot_shift_o)
);

bind main_mem bbc_mem_props u_ram_props (
	.clk_32m      (clk_32m),
	.rst_i        (1'b0),
	.mem_sync_i   (mem_sync_i),
	.wr_i         (req_i.we),
	.core_reset_i (1'b0),
	.shift_i      (1'b0)
);

//--- tb_bbc_mem_top.sv
`timescale 1ns/1ps
module tb_bbc_mem_top;
	import bbc_pkg::*;

	localparam int REMAP    = 16;
	localparam int AUTOBOOT = 40;
	localparam int TEST_LEN = 4 * 250 + 3 * (REMAP + AUTOBOOT + 60);
	localparam int TIMEOUT  = 2 * TEST_LEN;

	logic        clk_32m;
	logic        reset;
	logic        mem_sync_i;
	cpu_bus_t    cpu;
	logic [3:0]  romsel;
	status_t     status;
	loader_bus_t loader;
	logic        button_reset;
	logic        pll_ready;
	logic [7:0]  cpu_di;
	logic        core_reset;
	logic        autoboot_shift;

	logic [7:0]  rom_exp [0:47];
	logic [7:0]  ram_exp [0:15];
	logic [14:0] ram_adr [0:15];
	logic [31:0] rng;
	int          cycles;
	int          checks;
	int          errors;

	bbc_mem_top #(
		.REMAP_CYCLES    (REMAP),
		.AUTOBOOT_CYCLES (AUTOBOOT)
	) uut (
		.clk_32m          (clk_32m),
		.reset            (reset),
		.mem_sync_i       (mem_sync_i),
		.cpu_i            (cpu),
		.romsel_i         (romsel),
		.status_i         (status),
		.loader_i         (loader),
		.button_reset_i   (button_reset),
		.pll_ready_i      (pll_ready),
		.cpu_di_o         (cpu_di),
		.core_reset_o     (core_reset),
		.autoboot_shift_o (autoboot_shift)
	);

	initial begin
		clk_32m = 1'b0;
		forever #50 clk_32m = ~clk_32m;
	end

	always @(posedge clk_32m) begin
		mem_sync_i <= ~mem_sync_i;   // every second edge
		cycles <= cycles + 1;
		if (cycles > TIMEOUT) begin
			$display("timeout: run went past %0d cycles", TIMEOUT);
			$display("sim failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h exp %h", name, got, exp);
		end
	endtask

	// read cpu_di one cycle after the address
	task automatic cpu_read(input logic [15:0] a, input logic [3:0] rs, output logic [7:0] d);
		@(posedge clk_32m);
		cpu.addr.flat <= a;
		cpu.we <= 1'b0;
		romsel <= rs;
		@(posedge clk_32m);
		@(negedge clk_32m);
		d = cpu_di;
	endtask

	// line up so the write edge has mem_sync high
	task automatic sync_align();
		@(negedge clk_32m);
		while (mem_sync_i)
			@(negedge clk_32m);
		@(posedge clk_32m);
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [3:0] rs, input logic [7:0] d);
		sync_align();
		cpu.addr.flat <= a;
		cpu.we <= 1'b1;
		cpu.dout <= d;
		romsel <= rs;
		@(posedge clk_32m);
		cpu.we <= 1'b0;
	endtask

	task automatic loader_write(input logic [24:0] a, input logic [7:0] d);
		sync_align();
		loader.addr <= a;
		loader.data <= d;
		loader.we <= 1'b1;
		@(posedge clk_32m);
		loader.we <= 1'b0;
	endtask

	// cycles until core_reset reaches lvl or -1 past the limit
	task automatic wait_reset(input logic lvl, input int limit, output int n);
		n = 0;
		@(negedge clk_32m);
		while (core_reset !== lvl && n <= limit) begin
			@(negedge clk_32m);
			n++;
		end
		if (n > limit)
			n = -1;
	endtask

	task automatic report(input string name, input int err0);
		$display("%s: %s", name, (errors == err0) ? "ok" : "errors");
	endtask

	task automatic ram_readback();
		logic [7:0] d;
		int e0;
		e0 = errors;
		for (int i = 0; i < 16; i++) begin
			rng = xorshift(rng);
			ram_adr[i] = {rng[14:4], 4'(i)};   // low nibble keeps them distinct
			ram_exp[i] = rng[23:16];
			cpu_write({1'b0, ram_adr[i]}, 4'h0, ram_exp[i]);
		end
		for (int i = 0; i < 16; i++) begin
			cpu_read({1'b0, ram_adr[i]}, 4'h0, d);
			check_byte("cpu_di_o ram", d, ram_exp[i]);
		end
		report("test ram", e0);
	endtask

	task automatic rom_mapping();
		logic [7:0] d;
		int e0;
		e0 = errors;
		for (int i = 0; i < 16; i++) begin
			cpu_read(16'hc000 + 16'(i), 4'h0, d);
			check_byte("cpu_di_o mos", d, rom_exp[i]);
			cpu_read(16'h8000 + 16'(i), 4'he, d);
			check_byte("cpu_di_o basic hi", d, rom_exp[16 + i]);
			cpu_read(16'h8000 + 16'(i), 4'hc, d);
			check_byte("cpu_di_o mmfs hi", d, rom_exp[32 + i]);
		end
		cpu_read(16'h8005, 4'h3, d);
		check_byte("cpu_di_o unmapped", d, 8'hff);
		@(posedge clk_32m);
		status.rom_map_low <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			cpu_read(16'h8000 + 16'(i), 4'h0, d);
			check_byte("cpu_di_o basic lo", d, rom_exp[16 + i]);
			cpu_read(16'h8000 + 16'(i), 4'h2, d);
			check_byte("cpu_di_o mmfs lo", d, rom_exp[32 + i]);
		end
		cpu_read(16'h8005, 4'he, d);
		check_byte("cpu_di_o old basic", d, 8'hff);
		report("test roms", e0);
	endtask

	task automatic sideways_ram();
		logic [7:0] d;
		logic [7:0] base;
		int e0;
		e0 = errors;
		rng = xorshift(rng);
		base = rng[7:0];
		for (int b = 4; b < 8; b++)
			cpu_write(16'h9234, 4'(b), base + 8'(b));
		for (int b = 4; b < 8; b++) begin
			cpu_read(16'h9234, 4'(b), d);
			check_byte("cpu_di_o sideways", d, base + 8'(b));
		end
		cpu_write(16'h9234, 4'h9, 8'h12);
		cpu_read(16'h9234, 4'h9, d);
		check_byte("cpu_di_o bank 9", d, 8'hff);
		report("test sideways", e0);
	endtask

	task automatic loader_override();
		logic [7:0] d;
		int n;
		int e0;
		e0 = errors;
		@(posedge clk_32m);
		loader.active <= 1'b1;
		wait_reset(1'b1, 4, n);
		check_bit("core_reset_o loader", core_reset, 1'b1);
		for (int i = 0; i < 4; i++)
			loader_write({7'd1, 4'd5, 14'(16'h0100 + i)}, 8'hc0 + 8'(i));
		@(posedge clk_32m);
		loader.active <= 1'b0;
		for (int i = 0; i < 4; i++) begin
			cpu_read(16'h8100 + 16'(i), 4'h5, d);
			check_byte("cpu_di_o loader", d, 8'hc0 + 8'(i));
		end
		wait_reset(1'b0, 4, n);
		check_bit("core_reset_o after loader", core_reset, 1'b0);
		report("test loader", e0);
	endtask

	task automatic remap_cycle(input logic boot_en);
		int n;
		wait_reset(1'b0, 40, n);
		@(posedge clk_32m);
		status.autoboot_en <= boot_en;
		status.rom_map_low <= ~status.rom_map_low;
		wait_reset(1'b1, 4, n);
		check_bit("core_reset_o remap", core_reset, 1'b1);
		wait_reset(1'b0, REMAP + 2, n);
		if (n < 0) begin
			errors++;
			$display("core reset stayed high after the remap window");
		end else if (n < REMAP - 2) begin
			errors++;
			$display("core reset fell after %0d cycles of a %0d cycle remap window", n, REMAP);
		end
	endtask

	task automatic reset_autoboot();
		int n;
		int e0;
		e0 = errors;
		remap_cycle(1'b1);
		check_bit("autoboot_shift_o on", autoboot_shift, 1'b1);
		n = 0;
		while (autoboot_shift === 1'b1 && n <= AUTOBOOT + 4) begin
			@(negedge clk_32m);
			n++;
		end
		if (n < AUTOBOOT || n > AUTOBOOT + 2) begin
			errors++;
			$display("autoboot window lasted %0d cycles, not %0d", n, AUTOBOOT);
		end
		remap_cycle(1'b0);
		for (int i = 0; i < AUTOBOOT + 4; i++) begin
			check_bit("autoboot_shift_o off", autoboot_shift, 1'b0);
			@(negedge clk_32m);
		end
		report("test reset and autoboot", e0);
	endtask

	initial begin
		int n;
		$readmemh("rom_image.hex", rom_exp);
		rng = 32'd19;
		cycles = 0;
		checks = 0;
		errors = 0;
		reset = 1'b1;
		mem_sync_i = 1'b0;
		cpu = '0;
		romsel = 4'h0;
		status = '0;
		status.autoboot_en = 1'b1;   // counter must still hold shift low in reset
		loader = '0;
		button_reset = 1'b0;
		pll_ready = 1'b1;
		repeat (2) @(posedge clk_32m);
		@(negedge clk_32m);
		check_bit("core_reset_o in reset", core_reset, 1'b1);
		check_bit("autoboot_shift_o in reset", autoboot_shift, 1'b0);
		@(posedge clk_32m);
		reset <= 1'b0;
		wait_reset(1'b0, 4, n);
		check_bit("core_reset_o after reset", core_reset, 1'b0);
		ram_readback();
		rom_mapping();
		sideways_ram();
		loader_override();
		reset_autoboot();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- rom_image.hex
// one byte per line: mos 00-0f, basic 10-1f, mmfs 20-2f
5a
7f
a4
c9
ee
13
38
5d
82
a7
cc
f1
16
3b
60
85
aa
cf
f4
19
3e
63
88
ad
d2
f7
1c
41
66
8b
b0
d5
fa
1f
44
69
8e
b3
d8
fd
22
47
6c
91
b6
db
00
25

//--- verilog.f
bbc_pkg.sv
mem_map_decode.sv
sys_reset_ctrl.sv
rom_bank.sv
main_mem.sv
bbc_mem_top.sv
bbc_mem_props.sv
tb_bbc_mem_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_bbc_mem_top
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
